//--- verilog/fixedPkg.sv
package fixedPkg;

    // ---------------------------------------------------------------------
    // scalar format
    // ---------------------------------------------------------------------

    // signed Q16.16
    localparam int fixedWidth = 32;
    localparam int fixedFracBits = 16;

    typedef struct packed {
        logic signed [fixedWidth-1:0] value;
    } Fixed;

    // ---------------------------------------------------------------------
    // vector and box
    // ---------------------------------------------------------------------

    // x sits in the top word
    typedef struct packed {
        Fixed x;
        Fixed y;
        Fixed z;
    } Fixed3;

    // min corner first, max corner second
    typedef struct packed {
        Fixed3 min;
        Fixed3 max;
    } Aabb;

    // ---------------------------------------------------------------------
    // arithmetic helpers
    // ---------------------------------------------------------------------

    // plain two's complement add, carry out dropped
    function automatic Fixed fixedAdd(Fixed a, Fixed b);
        Fixed sum;
        sum.value = a.value + b.value;
        return sum;
    endfunction

    // per axis add
    function automatic Fixed3 fixed3Add(Fixed3 a, Fixed3 b);
        Fixed3 sum;
        sum.x = fixedAdd(a.x, b.x);
        sum.y = fixedAdd(a.y, b.y);
        sum.z = fixedAdd(a.z, b.z);
        return sum;
    endfunction

    // one unit, handy for scene setup
    localparam Fixed fixedOne = '{value: 32'sd1 <<< fixedFracBits};

endpackage

//--- verilog/bvhPkg.sv
package bvhPkg;

    import fixedPkg::*;

    // ---------------------------------------------------------------------
    // sizes
    // ---------------------------------------------------------------------

    localparam int coreCount = 2;
    localparam int nodeIndexWidth = 16;
    localparam int nodeDepth = 64;
    localparam int leafDepth = 64;
    localparam int nodeAddrWidth = $clog2(nodeDepth);
    localparam int leafAddrWidth = $clog2(leafDepth);

    // ---------------------------------------------------------------------
    // raw record layout, msb first
    // ---------------------------------------------------------------------

    localparam int byteWidth = 8;
    localparam int primitiveIndexWidth = 32;
    localparam int primitiveCountWidth = 8;

    // six box words then two child refs
    localparam int nodeRawWidth = 6 * fixedWidth + 2 * nodeIndexWidth;
    // start primitive then count
    localparam int leafRawWidth = primitiveIndexWidth + primitiveCountWidth;

    localparam int nodeBytes = nodeRawWidth / byteWidth;
    localparam int leafBytes = leafRawWidth / byteWidth;
    localparam int nodeByteCountWidth = $clog2(nodeBytes);
    localparam int leafByteCountWidth = $clog2(leafBytes);

    localparam logic [primitiveIndexWidth-1:0] nullPrimitiveIndex = '1;

    // ---------------------------------------------------------------------
    // child reference, top bit set means leaf
    // ---------------------------------------------------------------------

    typedef struct packed {
        logic isLeaf;
        logic [nodeIndexWidth-2:0] index;
    } ChildNodeView;

    // low bits hold ~leafIndex
    typedef struct packed {
        logic isLeaf;
        logic [nodeIndexWidth-2:0] invIndex;
    } ChildLeafView;

    typedef union packed {
        ChildNodeView node;
        ChildLeafView leaf;
    } ChildRef;

    // ---------------------------------------------------------------------
    // decoded records
    // ---------------------------------------------------------------------

    typedef struct packed {
        Aabb box;
        ChildRef left;
        ChildRef right;
    } BvhNode;

    typedef struct packed {
        logic [primitiveIndexWidth-1:0] startPrimitive;
        logic [primitiveCountWidth-1:0] numPrimitives;
    } BvhLeaf;

    // what a non-leaf child reports
    localparam BvhLeaf nullLeaf = '{startPrimitive: nullPrimitiveIndex, numPrimitives: '0};

    // ---------------------------------------------------------------------
    // load stream
    // ---------------------------------------------------------------------

    typedef enum logic {
        targetNode = 1'b0,
        targetLeaf = 1'b1
    } LoadTarget;

    typedef struct packed {
        logic valid;
        LoadTarget target;
        logic [byteWidth-1:0] data;
    } LoadByte;

endpackage

//--- verilog/offsetAabb.sv
`timescale 1ns/1ps

module offsetAabb
    import fixedPkg::*;
(
    input  Fixed3 offset,
    input  Aabb   box,
    output Aabb   shifted
);

    // ---------------------------------------------------------------------
    // translate both corners by the scene offset
    // ---------------------------------------------------------------------

    // no saturation, scene is expected to fit
    always_comb begin
        // min corner
        shifted.min = fixed3Add(box.min, offset);
        // max corner, same offset per axis
        shifted.max = fixed3Add(box.max, offset);
    end

endmodule

//--- verilog/bvhStore.sv
`timescale 1ns/1ps

module bvhStore
    import bvhPkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  LoadByte                   loadByte,
    input  logic                      loadEnd,
    output logic                      initDone,
    input  logic [nodeIndexWidth-1:0] nodeAddr [coreCount][2],
    output logic [nodeRawWidth-1:0]   nodeRaw [coreCount][2],
    input  logic [leafAddrWidth-1:0]  leafAddr [coreCount][2][2],
    output logic [leafRawWidth-1:0]   leafRaw [coreCount][2][2]
);

    // record storage
    logic [nodeRawWidth-1:0] nodeMem [nodeDepth];
    logic [leafRawWidth-1:0] leafMem [leafDepth];

    // entries written since reset, unwritten ones read as zero
    logic [nodeDepth-1:0] nodeWritten;
    logic [leafDepth-1:0] leafWritten;

    // assembly, holds every byte but the last
    logic [nodeRawWidth-byteWidth-1:0] nodeShift;
    logic [leafRawWidth-byteWidth-1:0] leafShift;

    logic [nodeByteCountWidth-1:0] nodeByteCount;
    logic [leafByteCountWidth-1:0] leafByteCount;
    logic [nodeAddrWidth-1:0] nodeWriteAddr;
    logic [leafAddrWidth-1:0] leafWriteAddr;

    logic nodeByte;
    logic leafByte;
    logic nodeLast;
    logic leafLast;

    // ---------------------------------------------------------------------
    // byte stream decode
    // ---------------------------------------------------------------------

    assign nodeByte = loadByte.valid && (loadByte.target == targetNode);
    assign leafByte = loadByte.valid && (loadByte.target == targetLeaf);
    assign nodeLast = nodeByteCount == nodeByteCountWidth'(nodeBytes - 1);
    assign leafLast = leafByteCount == leafByteCountWidth'(leafBytes - 1);

    // counters, write pointers, written flags
    always_ff @(posedge clk) begin
        if (reset) begin
            nodeByteCount <= '0;
            leafByteCount <= '0;
            nodeWriteAddr <= '0;
            leafWriteAddr <= '0;
            nodeWritten <= '0;
            leafWritten <= '0;
            initDone <= 1'b0;
        end else begin
            if (nodeByte) begin
                if (nodeLast) begin
                    nodeByteCount <= '0;
                    nodeWriteAddr <= nodeWriteAddr + 1'b1;
                    nodeWritten[nodeWriteAddr] <= 1'b1;
                end else begin
                    nodeByteCount <= nodeByteCount + 1'b1;
                end
            end
            if (leafByte) begin
                if (leafLast) begin
                    leafByteCount <= '0;
                    leafWriteAddr <= leafWriteAddr + 1'b1;
                    leafWritten[leafWriteAddr] <= 1'b1;
                end else begin
                    leafByteCount <= leafByteCount + 1'b1;
                end
            end
            // sticky until next reset
            if (loadEnd) begin
                initDone <= 1'b1;
            end
        end
    end

    // shift in msb first, write on the final byte
    always_ff @(posedge clk) begin
        if (nodeByte) begin
            nodeShift <= {nodeShift[nodeRawWidth-2*byteWidth-1:0], loadByte.data};
            if (nodeLast) begin
                nodeMem[nodeWriteAddr] <= {nodeShift, loadByte.data};
            end
        end
        if (leafByte) begin
            leafShift <= {leafShift[leafRawWidth-2*byteWidth-1:0], loadByte.data};
            if (leafLast) begin
                leafMem[leafWriteAddr] <= {leafShift, loadByte.data};
            end
        end
    end

    // ---------------------------------------------------------------------
    // registered read ports
    // ---------------------------------------------------------------------

    // node index wraps at nodeDepth
    always_ff @(posedge clk) begin
        for (int c = 0; c < coreCount; c++) begin
            for (int p = 0; p < 2; p++) begin
                nodeRaw[c][p] <= nodeWritten[nodeAddr[c][p][nodeAddrWidth-1:0]]
                    ? nodeMem[nodeAddr[c][p][nodeAddrWidth-1:0]] : '0;
                for (int k = 0; k < 2; k++) begin
                    leafRaw[c][p][k] <= leafWritten[leafAddr[c][p][k]]
                        ? leafMem[leafAddr[c][p][k]] : '0;
                end
            end
        end
    end

endmodule

//--- verilog/bvhNodeQuery.sv
`timescale 1ns/1ps

module bvhNodeQuery
    import fixedPkg::*;
    import bvhPkg::*;
(
    input  logic [nodeRawWidth-1:0] nodeRaw,
    input  Fixed3                   offset,
    output BvhNode                  node
);

    Aabb rawBox;
    Aabb shiftedBox;

    // ---------------------------------------------------------------------
    // unpack, box words from the top down
    // ---------------------------------------------------------------------

    always_comb begin
        rawBox.min.x.value = nodeRaw[nodeRawWidth-1 -: fixedWidth];
        rawBox.min.y.value = nodeRaw[nodeRawWidth-1-fixedWidth -: fixedWidth];
        rawBox.min.z.value = nodeRaw[nodeRawWidth-1-2*fixedWidth -: fixedWidth];
        // max corner follows
        rawBox.max.x.value = nodeRaw[nodeRawWidth-1-3*fixedWidth -: fixedWidth];
        rawBox.max.y.value = nodeRaw[nodeRawWidth-1-4*fixedWidth -: fixedWidth];
        rawBox.max.z.value = nodeRaw[nodeRawWidth-1-5*fixedWidth -: fixedWidth];
    end

    // scene offset
    offsetAabb offset_i (
        .offset (offset),
        .box    (rawBox),
        .shifted(shiftedBox)
    );

    // child refs pass through untouched
    always_comb begin
        node.box = shiftedBox;
        node.left = nodeRaw[2*nodeIndexWidth-1 -: nodeIndexWidth];
        node.right = nodeRaw[nodeIndexWidth-1:0];
    end

endmodule

//--- verilog/bvhLeafQuery.sv
`timescale 1ns/1ps

module bvhLeafQuery
    import bvhPkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  ChildRef                  child,
    output logic [leafAddrWidth-1:0] leafAddr,
    input  logic [leafRawWidth-1:0]  leafRaw,
    output BvhLeaf                   leaf
);

    // flag delayed to match the memory read
    logic isLeafQ;

    // ---------------------------------------------------------------------
    // address side
    // ---------------------------------------------------------------------

    // undo the inversion, drop bits beyond leafDepth
    // node-form children still issue a read, result discarded later
    assign leafAddr = ~child.leaf.invIndex[leafAddrWidth-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            isLeafQ <= 1'b0;
        end else begin
            isLeafQ <= child.leaf.isLeaf;
        end
    end

    // ---------------------------------------------------------------------
    // data side
    // ---------------------------------------------------------------------

    always_comb begin
        if (isLeafQ) begin
            // start primitive in the upper word
            leaf.startPrimitive = leafRaw[leafRawWidth-1 -: primitiveIndexWidth];
            leaf.numPrimitives = leafRaw[primitiveCountWidth-1:0];
        end else begin
            // interior child, nothing to test
            leaf = nullLeaf;
        end
    end

endmodule

//--- verilog/bvhStructure.sv
`timescale 1ns/1ps

module bvhStructure
    import fixedPkg::*;
    import bvhPkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  LoadByte                   loadByte,
    input  logic                      loadEnd,
    output logic                      initDone,
    input  Fixed3                     offset,
    input  logic [nodeIndexWidth-1:0] nodeIndex [coreCount][2],
    output BvhNode                    nodes [coreCount][2],
    output BvhLeaf                    leaves [coreCount][2][2]
);

    // store to node query, one cycle after the index
    logic [nodeRawWidth-1:0] nodeRaw [coreCount][2];
    // leaf query to store and back
    logic [leafAddrWidth-1:0] leafAddr [coreCount][2][2];
    logic [leafRawWidth-1:0] leafRaw [coreCount][2][2];

    // ---------------------------------------------------------------------
    // storage
    // ---------------------------------------------------------------------

    bvhStore store_i (
        .clk     (clk),
        .reset   (reset),
        .loadByte(loadByte),
        .loadEnd (loadEnd),
        .initDone(initDone),
        .nodeAddr(nodeIndex),
        .nodeRaw (nodeRaw),
        .leafAddr(leafAddr),
        .leafRaw (leafRaw)
    );

    // ---------------------------------------------------------------------
    // per core, per port, per child
    // ---------------------------------------------------------------------

    for (genvar c = 0; c < coreCount; c++) begin : coreGen
        for (genvar p = 0; p < 2; p++) begin : portGen
            bvhNodeQuery nodeQuery_i (
                .nodeRaw(nodeRaw[c][p]),
                .offset (offset),
                .node   (nodes[c][p])
            );
            // child 0 is left, child 1 is right
            for (genvar k = 0; k < 2; k++) begin : childGen
                bvhLeafQuery leafQuery_i (
                    .clk     (clk),
                    .reset   (reset),
                    .child   (k == 0 ? nodes[c][p].left : nodes[c][p].right),
                    .leafAddr(leafAddr[c][p][k]),
                    .leafRaw (leafRaw[c][p][k]),
                    .leaf    (leaves[c][p][k])
                );
            end
        end
    end

endmodule

//--- tests/bvhStructureProps.sv
`timescale 1ns/1ps

module bvhStructureProps
    import bvhPkg::*;
(
    input logic   clk,
    input logic   reset,
    input logic   loadEnd,
    input logic   initDone,
    input BvhNode nodes [coreCount][2],
    input BvhLeaf leaves [coreCount][2][2]
);

    // ----------------------------------------------------------------------
    // init flag
    // ----------------------------------------------------------------------

    resetClears: assert property (@(posedge clk) reset |=> !initDone)
        else $error("initDone high after a reset cycle");

    // set only by the loadEnd pulse one cycle earlier
    risesOnLoadEnd: assert property (@(posedge clk) disable iff (reset)
        $rose(initDone) |-> $past(loadEnd))
        else $error("initDone rose without loadEnd");

    holdsHigh: assert property (@(posedge clk) disable iff (reset)
        initDone |=> initDone)
        else $error("initDone fell without reset");

    // ----------------------------------------------------------------------
    // interior children give the null leaf
    // ----------------------------------------------------------------------

    // nodes lag the index by one cycle, leaves by two
    for (genvar c = 0; c < coreCount; c++) begin : coreGen
        for (genvar p = 0; p < 2; p++) begin : portGen
            leftNull: assert property (@(posedge clk) disable iff (reset)
                !nodes[c][p].left.node.isLeaf |=> leaves[c][p][0] == nullLeaf)
                else $error("left interior child did not give the null leaf");
            rightNull: assert property (@(posedge clk) disable iff (reset)
                !nodes[c][p].right.node.isLeaf |=> leaves[c][p][1] == nullLeaf)
                else $error("right interior child did not give the null leaf");
        end
    end

endmodule

bind bvhStructure bvhStructureProps props_i (
    .clk     (clk),
    .reset   (reset),
    .loadEnd (loadEnd),
    .initDone(initDone),
    .nodes   (nodes),
    .leaves  (leaves)
);

//--- tests/bvhStructureTb.sv
`timescale 1ns/1ps

module bvhStructureTb
    import fixedPkg::*;
    import bvhPkg::*;
();

    localparam int clkPeriod = 10;
    localparam int setsPerOffset = 48;
    localparam int offsetCount = 6;
    // one byte per cycle, no gaps
    localparam int loadCycles = nodeDepth * nodeBytes + leafDepth * leafBytes;
    localparam int queryCycles = 2 * (nodeDepth + offsetCount * (setsPerOffset + 5));
    localparam int timeoutCycles = loadCycles + queryCycles + 200;

    // one index set as seen on the inputs
    typedef struct packed {
        logic active;
        logic [coreCount-1:0][1:0][nodeIndexWidth-1:0] index;
        Fixed3 offset;
    } Request;

    logic clk;
    logic reset;
    LoadByte loadByte;
    logic loadEnd;
    logic initDone;
    Fixed3 offset;
    logic [nodeIndexWidth-1:0] nodeIndex [coreCount][2];
    BvhNode nodes [coreCount][2];
    BvhLeaf leaves [coreCount][2][2];

    // memory images, zero until filled
    logic [nodeRawWidth-1:0] nodeImage [nodeDepth];
    logic [leafRawWidth-1:0] leafImage [leafDepth];

    logic queryActive;
    logic doneExpected = 1'b0;
    // newest request at the front
    Request pipe [$];
    integer seed = 32'h311;
    int nodeErrors = 0;
    int leafErrors = 0;
    int doneErrors = 0;

    bvhStructure dut_i (
        .clk      (clk),
        .reset    (reset),
        .loadByte (loadByte),
        .loadEnd  (loadEnd),
        .initDone (initDone),
        .offset   (offset),
        .nodeIndex(nodeIndex),
        .nodes    (nodes),
        .leaves   (leaves)
    );

    initial begin : clockGen
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // reference model
    // ----------------------------------------------------------------------

    // record layout: min xyz, max xyz, left, right, msb first
    function automatic BvhNode expectNode(logic [nodeIndexWidth-1:0] index, Fixed3 off);
        logic [nodeRawWidth-1:0] raw;
        logic [fixedWidth-1:0] word [6];
        logic [fixedWidth-1:0] axisOffset [3];
        BvhNode exp;
        raw = nodeImage[index % nodeDepth];
        axisOffset[0] = off.x.value;
        axisOffset[1] = off.y.value;
        axisOffset[2] = off.z.value;
        // 32-bit wrap comes from the word width
        for (int w = 0; w < 6; w++) begin
            word[w] = raw[nodeRawWidth-1-w*fixedWidth -: fixedWidth] + axisOffset[w % 3];
        end
        exp.box.min.x.value = word[0];
        exp.box.min.y.value = word[1];
        exp.box.min.z.value = word[2];
        exp.box.max.x.value = word[3];
        exp.box.max.y.value = word[4];
        exp.box.max.z.value = word[5];
        exp.left = raw[2*nodeIndexWidth-1 -: nodeIndexWidth];
        exp.right = raw[nodeIndexWidth-1:0];
        return exp;
    endfunction

    // top bit is the leaf flag, low bits hold the inverted leaf index
    function automatic BvhLeaf expectLeaf(ChildRef child);
        logic [nodeIndexWidth-1:0] bits;
        logic [nodeIndexWidth-2:0] inv;
        logic [leafRawWidth-1:0] raw;
        BvhLeaf exp;
        bits = child;
        inv = ~bits[nodeIndexWidth-2:0];
        raw = leafImage[inv % leafDepth];
        if (bits[nodeIndexWidth-1]) begin
            exp.startPrimitive = raw[leafRawWidth-1 -: 32];
            exp.numPrimitives = raw[7:0];
        end else begin
            exp.startPrimitive = nullPrimitiveIndex;
            exp.numPrimitives = 8'h00;
        end
        return exp;
    endfunction

    // ----------------------------------------------------------------------
    // compare tasks
    // ----------------------------------------------------------------------

    task automatic compareNode(string name, BvhNode got, BvhNode exp);
        if (got !== exp) begin
            nodeErrors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic compareLeaf(string name, BvhLeaf got, BvhLeaf exp);
        if (got !== exp) begin
            leafErrors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic compareFlag(string name, logic got, logic exp);
        if (got !== exp) begin
            doneErrors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    // nodes one cycle after the index, leaves two
    always @(negedge clk) begin : checkOutputs
        Request now;
        BvhNode expNode;
        if (!reset) begin
            compareFlag("initDone", initDone, doneExpected);
            if (loadEnd) begin
                doneExpected = 1'b1;
            end
            if (pipe.size() > 0 && pipe[0].active) begin
                for (int c = 0; c < coreCount; c++) begin
                    for (int p = 0; p < 2; p++) begin
                        expNode = expectNode(pipe[0].index[c][p], pipe[0].offset);
                        compareNode($sformatf("nodes[%0d][%0d]", c, p), nodes[c][p], expNode);
                    end
                end
            end
            if (pipe.size() > 1 && pipe[1].active) begin
                for (int c = 0; c < coreCount; c++) begin
                    for (int p = 0; p < 2; p++) begin
                        expNode = expectNode(pipe[1].index[c][p], pipe[1].offset);
                        compareLeaf($sformatf("leaves[%0d][%0d][0]", c, p),
                            leaves[c][p][0], expectLeaf(expNode.left));
                        compareLeaf($sformatf("leaves[%0d][%0d][1]", c, p),
                            leaves[c][p][1], expectLeaf(expNode.right));
                    end
                end
            end
            // capture what the DUT samples at the next edge
            now.active = queryActive;
            now.offset = offset;
            for (int c = 0; c < coreCount; c++) begin
                for (int p = 0; p < 2; p++) begin
                    now.index[c][p] = nodeIndex[c][p];
                end
            end
            pipe.push_front(now);
            if (pipe.size() > 2) begin
                void'(pipe.pop_back());
            end
        end
    end

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------

    // random boxes, one leaf child per node naming leaf i
    task automatic fillNodeImage();
        logic [fixedWidth-1:0] word;
        logic [nodeIndexWidth-1:0] leafChild;
        logic [nodeIndexWidth-1:0] nodeChild;
        for (int i = 0; i < nodeDepth; i++) begin
            for (int w = 0; w < 6; w++) begin
                word = $random(seed);
                nodeImage[i][nodeRawWidth-1-w*fixedWidth -: fixedWidth] = word;
            end
            // random upper bits, so the modulo is exercised
            leafChild = nodeIndexWidth'($random(seed));
            leafChild[nodeIndexWidth-1] = 1'b1;
            leafChild[leafAddrWidth-1:0] = ~i[leafAddrWidth-1:0];
            nodeChild = nodeIndexWidth'($random(seed));
            nodeChild[nodeIndexWidth-1] = 1'b0;
            // leaf side alternates
            if (i % 2 == 0) begin
                nodeImage[i][2*nodeIndexWidth-1:0] = {leafChild, nodeChild};
            end else begin
                nodeImage[i][2*nodeIndexWidth-1:0] = {nodeChild, leafChild};
            end
        end
    endtask

    // random start and count per leaf
    task automatic fillLeafImage();
        logic [fixedWidth-1:0] word;
        for (int i = 0; i < leafDepth; i++) begin
            word = $random(seed);
            leafImage[i] = {word, 8'($random(seed))};
        end
    endtask

    // node records, msb first
    task automatic streamNodes();
        LoadByte b;
        for (int i = 0; i < nodeDepth; i++) begin
            for (int k = nodeBytes - 1; k >= 0; k--) begin
                b.valid = 1'b1;
                b.target = targetNode;
                b.data = nodeImage[i][k*byteWidth +: byteWidth];
                @(posedge clk);
                loadByte <= b;
            end
        end
        @(posedge clk);
        loadByte <= '0;
    endtask

    // leaf records, msb first, then the end pulse
    task automatic streamLeaves();
        LoadByte b;
        for (int i = 0; i < leafDepth; i++) begin
            for (int k = leafBytes - 1; k >= 0; k--) begin
                b.valid = 1'b1;
                b.target = targetLeaf;
                b.data = leafImage[i][k*byteWidth +: byteWidth];
                @(posedge clk);
                loadByte <= b;
            end
        end
        @(posedge clk);
        loadByte <= '0;
        @(posedge clk);
        loadEnd <= 1'b1;
        @(posedge clk);
        loadEnd <= 1'b0;
    endtask

    task automatic issueRandomSet();
        @(posedge clk);
        for (int c = 0; c < coreCount; c++) begin
            for (int p = 0; p < 2; p++) begin
                nodeIndex[c][p] <= nodeIndexWidth'($random(seed));
            end
        end
        queryActive <= 1'b1;
    endtask

    // every node once, all slots busy
    task automatic issueSweep();
        for (int n = 0; n < nodeDepth; n += coreCount * 2) begin
            @(posedge clk);
            for (int c = 0; c < coreCount; c++) begin
                for (int p = 0; p < 2; p++) begin
                    nodeIndex[c][p] <= nodeIndexWidth'(n + c * 2 + p);
                end
            end
            queryActive <= 1'b1;
        end
    endtask

    // let the pipeline empty before touching the offset
    task automatic drain();
        @(posedge clk);
        queryActive <= 1'b0;
        repeat (3) @(posedge clk);
    endtask

    initial begin : mainFlow
        Fixed3 offsetList [offsetCount];
        int total;
        reset = 1'b1;
        loadByte = '0;
        loadEnd = 1'b0;
        offset = '0;
        queryActive = 1'b0;
        for (int c = 0; c < coreCount; c++) begin
            nodeIndex[c][0] = '0;
            nodeIndex[c][1] = '0;
        end
        for (int i = 0; i < nodeDepth; i++) begin
            nodeImage[i] = '0;
        end
        for (int i = 0; i < leafDepth; i++) begin
            leafImage[i] = '0;
        end
        // zero, positive, negative, near the wrap point, then random
        offsetList[0] = '0;
        offsetList[1] = {32'h0001_8000, 32'h0003_0000, 32'h0000_4000};
        offsetList[2] = {32'hfffe_0000, 32'hffff_8000, 32'hff9c_0000};
        offsetList[3] = {32'h7fff_ffff, 32'h8000_0000, 32'hc000_0000};
        offsetList[4] = {$random(seed), $random(seed), $random(seed)};
        offsetList[5] = {$random(seed), $random(seed), $random(seed)};

        repeat (4) @(posedge clk);
        reset <= 1'b0;

        // memories still empty
        repeat (8) issueRandomSet();
        drain();

        // nodes only, leaf children still read zero
        fillNodeImage();
        streamNodes();
        issueSweep();
        drain();

        fillLeafImage();
        streamLeaves();

        // read back at zero offset
        issueSweep();
        drain();

        for (int o = 0; o < offsetCount; o++) begin
            @(posedge clk);
            offset <= offsetList[o];
            repeat (setsPerOffset) issueRandomSet();
            drain();
        end

        total = nodeErrors + leafErrors + doneErrors;
        $display("errors: node %0d, leaf %0d, initDone %0d", nodeErrors, leafErrors, doneErrors);
        if (total == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(timeoutCycles * clkPeriod);
        $display("watchdog expired before the test sequence finished");
        $display("tests failed");
        $finish;
    end

endmodule

//--- all.f
verilog/fixedPkg.sv
verilog/bvhPkg.sv
verilog/offsetAabb.sv
verilog/bvhStore.sv
verilog/bvhNodeQuery.sv
verilog/bvhLeafQuery.sv
verilog/bvhStructure.sv
tests/bvhStructureProps.sv
tests/bvhStructureTb.sv

//--- Makefile
TOOL      = verilator
LINTFLAGS = --lint-only --timing --assert
SIMFLAGS  = --binary --timing --assert -Wno-fatal
TOP       = bvhStructureTb
FILELIST  = all.f
OBJDIR    = obj_dir
LOG       = sim.log
PASS      = all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o $(TOP)
	-$(OBJDIR)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
